//--- verilog/mm_sched_pkg.sv
package mm_sched_pkg;

    localparam int DIM_W      = 4;
    localparam int BLOCK_HALF = 4;     // A dimension above this is split in two
    localparam int NUM_OPS    = 8;
    localparam int OP_W       = 3;
    localparam int ORDER_W    = 4;
    localparam int ADDR_W     = 3;
    localparam int BURST_LEN  = 4;
    localparam int FIFO_DEPTH = 4;     // Power of two so the pointers wrap

    localparam int BEAT_W     = $clog2(BURST_LEN);
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1);

    // Block orders 3 and 4 live in the upper half of each memory
    localparam int ORDER_HI   = 3;

    localparam int FSM_W = 2;
    localparam logic [FSM_W-1:0] FETCH_IDLE  = 2'd0;
    localparam logic [FSM_W-1:0] FETCH_BURST = 2'd1;
    localparam logic [FSM_W-1:0] FETCH_WAIT  = 2'd2;

    // Matrix dimensions with M in the top nibble
    typedef struct packed {
        logic [DIM_W-1:0] m;
        logic [DIM_W-1:0] n;
        logic [DIM_W-1:0] t;
    } mnt_t;

    // Operation index k-1 with one select bit per dimension half
    typedef struct packed {
        logic t_sel;
        logic m_sel;
        logic n_sel;
    } op_t;

    typedef struct packed {
        logic [ORDER_W-1:0] i_order;   // Input block
        logic [ORDER_W-1:0] w_order;   // Weight block
    } orders_t;

    // Read request to input and weight memories
    typedef struct packed {
        logic              en_i;
        logic [ADDR_W-1:0] addr_i;
        logic              en_w;
        logic [ADDR_W-1:0] addr_w;
    } mem_req_t;

endpackage

//--- verilog/op_sequencer.sv
`timescale 1ns/100ps

module op_sequencer (
    input  logic               CLK,
    input  logic               RSTN,
    input  logic               i_start,
    input  mm_sched_pkg::mnt_t i_mnt,
    input  logic               i_full,
    output logic               o_push,
    output mm_sched_pkg::op_t  o_push_op
);

    import mm_sched_pkg::*;

    logic               busy;
    mnt_t               mnt_q;
    logic [NUM_OPS-1:0] op_mask;
    logic [OP_W-1:0]    cur_idx;
    logic [OP_W-1:0]    next_idx;
    logic               hit;
    logic               more_ops;   // Another enabled index above next_idx

    // Op k-1 runs when each of its select bits points at a large dimension
    function automatic logic [NUM_OPS-1:0] build_mask(input mnt_t dims);
        logic [NUM_OPS-1:0] mask;
        logic               t_big;
        logic               m_big;
        logic               n_big;
        op_t                op;
        t_big = (dims.t > DIM_W'(BLOCK_HALF));
        m_big = (dims.m > DIM_W'(BLOCK_HALF));
        n_big = (dims.n > DIM_W'(BLOCK_HALF));
        for (int k = 0; k < NUM_OPS; k++) begin
            op      = op_t'(OP_W'(k));
            mask[k] = (!op.t_sel || t_big) && (!op.m_sel || m_big) && (!op.n_sel || n_big);
        end
        return mask;
    endfunction

    assign op_mask = build_mask(mnt_q);

    // Lowest enabled index at or above cur_idx
    always_comb begin
        hit      = 1'b0;
        more_ops = 1'b0;
        next_idx = cur_idx;
        for (int i = NUM_OPS - 1; i >= 0; i--) begin
            if (op_mask[i] && (OP_W'(i) >= cur_idx)) begin
                more_ops = hit;     // A previous hit sits higher up
                hit      = 1'b1;
                next_idx = OP_W'(i);
            end
        end
    end

    assign o_push    = busy && hit;
    assign o_push_op = op_t'(next_idx);

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            busy    <= 1'b0;
            cur_idx <= '0;
        end else if (!busy) begin
            if (i_start) begin
                busy    <= 1'b1;
                cur_idx <= '0;
            end
        end else if (o_push && !i_full) begin
            cur_idx <= next_idx + OP_W'(1);
            busy    <= more_ops;   // Idle after the last enabled op
        end
    end

    always_ff @(posedge CLK) begin
        if (i_start && !busy) begin
            mnt_q <= i_mnt;
        end
    end

endmodule

//--- verilog/op_fifo.sv
`timescale 1ns/100ps

module op_fifo (
    input  logic              CLK,
    input  logic              RSTN,
    input  logic              i_push,
    input  mm_sched_pkg::op_t i_push_op,
    input  logic              i_pop,
    output logic              o_full,
    output logic              o_empty,
    output mm_sched_pkg::op_t o_head_op
);

    import mm_sched_pkg::*;

    op_t                mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_CW-1:0] count;
    logic               wr_en;
    logic               rd_en;

    assign o_full  = (count == FIFO_CW'(FIFO_DEPTH));
    assign o_empty = (count == '0);

    assign wr_en = i_push && !o_full;    // Rejected while full
    assign rd_en = i_pop && !o_empty;

    assign o_head_op = mem[rd_ptr];

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + FIFO_AW'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + FIFO_AW'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + FIFO_CW'(1);
                2'b01:   count <= count - FIFO_CW'(1);
                default: count <= count;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_push_op;
        end
    end

endmodule

//--- verilog/block_fetch.sv
`timescale 1ns/100ps

module block_fetch (
    input  logic                   CLK,
    input  logic                   RSTN,
    input  logic                   i_empty,
    input  mm_sched_pkg::op_t      i_head_op,
    input  logic                   i_operation_done,
    output logic                   o_pop,
    output logic                   o_op_start,
    output mm_sched_pkg::orders_t  o_orders,
    output mm_sched_pkg::mem_req_t o_mem
);

    import mm_sched_pkg::*;

    logic [FSM_W-1:0]  state;
    logic [BEAT_W-1:0] beat;
    logic              last_beat;
    logic              in_burst;
    orders_t           orders_q;
    orders_t           head_orders;

    // Take the next op as soon as the previous one is done
    assign o_pop      = (state == FETCH_IDLE) && !i_empty;
    assign o_op_start = o_pop;

    // Select bits read as a binary offset from block 1
    always_comb begin
        head_orders.i_order = ORDER_W'({i_head_op.t_sel, i_head_op.n_sel}) + ORDER_W'(1);
        head_orders.w_order = ORDER_W'({i_head_op.m_sel, i_head_op.n_sel}) + ORDER_W'(1);
    end

    assign o_orders = o_op_start ? head_orders : orders_q;   // New orders on the start cycle

    assign in_burst  = (state == FETCH_BURST);
    assign last_beat = (beat == BEAT_W'(BURST_LEN - 1));

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            state    <= FETCH_IDLE;
            beat     <= '0;
            orders_q <= '0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (o_pop) begin
                        state    <= FETCH_BURST;
                        beat     <= '0;
                        orders_q <= head_orders;
                    end
                end
                FETCH_BURST: begin
                    if (last_beat) begin
                        state <= FETCH_WAIT;
                        beat  <= '0;
                    end else begin
                        beat <= beat + BEAT_W'(1);
                    end
                end
                FETCH_WAIT: begin
                    if (i_operation_done) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    // Upper half for blocks 3 and 4, beat number in the low bits
    always_comb begin
        o_mem = '0;
        if (in_burst) begin
            o_mem.en_i   = 1'b1;
            o_mem.addr_i = {(orders_q.i_order >= ORDER_W'(ORDER_HI)), beat};
            o_mem.en_w   = 1'b1;
            o_mem.addr_w = {(orders_q.w_order >= ORDER_W'(ORDER_HI)), beat};
        end
    end

endmodule

//--- verilog/mm_block_sched.sv
`timescale 1ns/100ps

module mm_block_sched (
    input  logic                   CLK,
    input  logic                   RSTN,
    input  logic                   i_start,
    input  mm_sched_pkg::mnt_t     i_mnt,
    input  logic                   i_operation_done,
    output logic                   o_op_start,
    output mm_sched_pkg::orders_t  o_orders,
    output mm_sched_pkg::mem_req_t o_mem
);

    import mm_sched_pkg::*;

    logic push;
    op_t  push_op;
    logic fifo_full;
    logic fifo_empty;
    op_t  head_op;
    logic pop;

    // Queues the enabled ops of a job
    op_sequencer u_seq (
        .CLK       (CLK),
        .RSTN      (RSTN),
        .i_start   (i_start),
        .i_mnt     (i_mnt),
        .i_full    (fifo_full),
        .o_push    (push),
        .o_push_op (push_op)
    );

    op_fifo u_fifo (
        .CLK       (CLK),
        .RSTN      (RSTN),
        .i_push    (push),
        .i_push_op (push_op),
        .i_pop     (pop),
        .o_full    (fifo_full),
        .o_empty   (fifo_empty),
        .o_head_op (head_op)
    );

    // Paced by i_operation_done
    block_fetch u_fetch (
        .CLK              (CLK),
        .RSTN             (RSTN),
        .i_empty          (fifo_empty),
        .i_head_op        (head_op),
        .i_operation_done (i_operation_done),
        .o_pop            (pop),
        .o_op_start       (o_op_start),
        .o_orders         (o_orders),
        .o_mem            (o_mem)
    );

endmodule

//--- sim/mm_sched_assertions.sv
`timescale 1ns/100ps

module mm_sched_assertions (
    input logic                   CLK,
    input logic                   RSTN,
    input logic                   i_op_start,
    input mm_sched_pkg::mem_req_t i_mem
);

    import mm_sched_pkg::*;

    int fail_count = 0;   // Read by the testbench
    int run_len;          // Consecutive cycles with the enables high

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            run_len <= 0;
        end else if (i_mem.en_i) begin
            run_len <= run_len + 1;
        end else begin
            run_len <= 0;
        end
    end

    a_single_start: assert property (@(posedge CLK) disable iff (!RSTN)
        i_op_start |=> !i_op_start)
    else begin
        fail_count++;
        $error("o_op_start high on two cycles in a row");
    end

    a_enables_match: assert property (@(posedge CLK) disable iff (!RSTN)
        i_mem.en_i == i_mem.en_w)
    else begin
        fail_count++;
        $error("en_i and en_w differ");
    end

    a_start_outside_burst: assert property (@(posedge CLK) disable iff (!RSTN)
        i_op_start |-> !i_mem.en_i)
    else begin
        fail_count++;
        $error("o_op_start high during a burst");
    end

    // Burst opens on the cycle after the start
    a_burst_follows_start: assert property (@(posedge CLK) disable iff (!RSTN)
        i_op_start |=> $rose(i_mem.en_i))
    else begin
        fail_count++;
        $error("No burst right after o_op_start");
    end

    a_burst_length: assert property (@(posedge CLK) disable iff (!RSTN)
        $fell(i_mem.en_i) |-> (run_len == BURST_LEN))
    else begin
        fail_count++;
        $error("Burst length is not BURST_LEN beats");
    end

endmodule

bind block_fetch mm_sched_assertions u_assert (
    .CLK        (CLK),
    .RSTN       (RSTN),
    .i_op_start (o_op_start),
    .i_mem      (o_mem)
);

//--- sim/tb_mm_block_sched.sv
`timescale 1ns/100ps

module tb_mm_block_sched;

    import mm_sched_pkg::*;

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 8;
    localparam int          NUM_ROWS     = 11;
    localparam int          MAX_GAP      = 5;     // Longest wait before done
    localparam int          START_LIMIT  = 40;    // Cycles allowed for an o_op_start
    localparam int          IDLE_CHECK   = 12;
    localparam logic [31:0] SEED         = 32'h939a6c75;
    localparam int          WATCHDOG_NS  =
        (NUM_ROWS * NUM_OPS * (BURST_LEN + MAX_GAP + 10) + RESET_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        mnt_t               mnt;
        logic [NUM_OPS-1:0] mask;    // Enabled ops, worked out by hand
        logic               early;   // Extra done pulse inside each burst
        logic               chain;   // Next row starts while this one runs
    } row_t;

    logic     CLK;
    logic     RSTN;
    logic     i_start;
    mnt_t     i_mnt;
    logic     i_operation_done;
    logic     o_op_start;
    orders_t  o_orders;
    mem_req_t o_mem;

    row_t     rows [NUM_ROWS];

    mm_block_sched dut (
        .CLK              (CLK),
        .RSTN             (RSTN),
        .i_start          (i_start),
        .i_mnt            (i_mnt),
        .i_operation_done (i_operation_done),
        .o_op_start       (o_op_start),
        .o_orders         (o_orders),
        .o_mem            (o_mem)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_orders(input orders_t got, input orders_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: o_orders got %h expected %h", got, exp));
        end
    endtask

    task automatic check_mem(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: o_mem got %h expected %h", got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_mask(input int row, input logic [NUM_OPS-1:0] got,
                              input logic [NUM_OPS-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: ref_mask row %0d got %h expected %h", row, got, exp));
        end
    endtask

    // An op is allowed only if none of its select bits names a small dimension
    function automatic logic [NUM_OPS-1:0] ref_mask(input mnt_t dims);
        logic [OP_W-1:0]    big;
        logic [NUM_OPS-1:0] mask;
        big = {dims.t > DIM_W'(BLOCK_HALF), dims.m > DIM_W'(BLOCK_HALF),
               dims.n > DIM_W'(BLOCK_HALF)};
        for (int k = 0; k < NUM_OPS; k++) begin
            mask[k] = ((OP_W'(k) & ~big) == '0);
        end
        return mask;
    endfunction

    // Index bits are t, m, n from the top
    function automatic orders_t exp_orders(input logic [OP_W-1:0] k);
        orders_t ord;
        ord.i_order = ORDER_W'(1 + int'(k[0]) + 2 * int'(k[2]));
        ord.w_order = ORDER_W'(1 + int'(k[0]) + 2 * int'(k[1]));
        return ord;
    endfunction

    function automatic mem_req_t exp_beat(input orders_t ord, input int beat);
        mem_req_t req;
        req.en_i   = 1'b1;
        req.addr_i = {ord.i_order >= ORDER_W'(3), BEAT_W'(beat)};
        req.en_w   = 1'b1;
        req.addr_w = {ord.w_order >= ORDER_W'(3), BEAT_W'(beat)};
        return req;
    endfunction

    // No start and no memory access for n cycles
    task automatic check_idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge CLK);
            check_bit("o_op_start", o_op_start, 1'b0);
            check_mem(o_mem, '0);
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic pulse_start(input mnt_t mnt);
        i_mnt   = mnt;
        i_start = 1'b1;
        @(posedge CLK);
        #1;
        i_start = 1'b0;
    endtask

    task automatic wait_op_start();
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while (!o_op_start) begin
            cycles++;
            if (cycles > START_LIMIT) begin
                fail_run("o_op_start did not arrive for an enabled operation");
            end
            @(negedge CLK);
        end
    endtask

    task automatic run_op(input logic [OP_W-1:0] k, input logic early, input logic launch,
                          input mnt_t next_mnt);
        orders_t ord;
        int      gap;
        ord = exp_orders(k);
        gap = int'($urandom_range(MAX_GAP, 0));
        wait_op_start();
        check_orders(o_orders, ord);
        for (int b = 0; b < BURST_LEN; b++) begin
            @(posedge CLK);
            #1;
            i_operation_done = early && (b == 1);   // Must be ignored
            if (launch && (b == 1)) begin
                i_start = 1'b1;                     // Sequencer just went idle
                i_mnt   = next_mnt;
            end else begin
                i_start = 1'b0;
            end
            @(negedge CLK);
            check_bit("o_op_start", o_op_start, 1'b0);
            check_mem(o_mem, exp_beat(ord, b));
            check_orders(o_orders, ord);            // Held until the next start
        end
        @(posedge CLK);
        #1;
        i_operation_done = 1'b0;
        i_start          = 1'b0;
        check_idle(gap);
        i_operation_done = 1'b1;
        @(negedge CLK);
        check_bit("o_op_start", o_op_start, 1'b0);
        check_mem(o_mem, '0);
        @(posedge CLK);
        #1;
        i_operation_done = 1'b0;
    endtask

    always @(negedge CLK) begin
        if (dut.u_fetch.u_assert.fail_count != 0) begin
            fail_run("An assertion on block_fetch failed");
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        fail_run("Watchdog expired, the run timed out");
    end

    initial begin : main
        logic chained;
        logic launch;
        int   nth;
        CLK              = 1'b0;
        RSTN             = 1'b0;
        i_start          = 1'b0;
        i_mnt            = '0;
        i_operation_done = 1'b0;
        void'($urandom(SEED));
        rows = '{
            '{mnt: 12'h444, mask: 8'h01, early: 1'b0, chain: 1'b0},   // All at the edge
            '{mnt: 12'h251, mask: 8'h03, early: 1'b1, chain: 1'b0},
            '{mnt: 12'h534, mask: 8'h05, early: 1'b0, chain: 1'b0},
            '{mnt: 12'h109, mask: 8'h11, early: 1'b0, chain: 1'b0},
            '{mnt: 12'h863, mask: 8'h0F, early: 1'b1, chain: 1'b0},
            '{mnt: 12'h3F5, mask: 8'h33, early: 1'b0, chain: 1'b0},
            '{mnt: 12'hC47, mask: 8'h55, early: 1'b0, chain: 1'b0},
            '{mnt: 12'h555, mask: 8'hFF, early: 1'b1, chain: 1'b1},   // Fills the FIFO
            '{mnt: 12'h6A2, mask: 8'h0F, early: 1'b0, chain: 1'b0},   // Queued behind row 7
            '{mnt: 12'h000, mask: 8'h01, early: 1'b0, chain: 1'b0},
            '{mnt: 12'hFFF, mask: 8'hFF, early: 1'b1, chain: 1'b0}
        };
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RSTN = 1'b1;
        check_idle(6);
        check_orders(o_orders, '0);
        chained = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            check_mask(r, ref_mask(rows[r].mnt), rows[r].mask);
            if (!chained) begin
                pulse_start(rows[r].mnt);
            end
            chained = 1'b0;
            nth     = 0;
            for (int k = 0; k < NUM_OPS; k++) begin
                if (rows[r].mask[k]) begin
                    launch = rows[r].chain && (nth == 3) && (r + 1 < NUM_ROWS);
                    run_op(OP_W'(k), rows[r].early, launch, rows[(r + 1) % NUM_ROWS].mnt);
                    chained = chained || launch;
                    nth++;
                end
            end
            if (!rows[r].chain) begin
                check_idle(IDLE_CHECK);   // No extra op after the job
            end
        end
        if (dut.u_fetch.u_assert.fail_count != 0) begin
            fail_run("An assertion on block_fetch failed");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- files.f
verilog/mm_sched_pkg.sv
verilog/op_sequencer.sv
verilog/op_fifo.sv
verilog/block_fetch.sv
verilog/mm_block_sched.sv
sim/mm_sched_assertions.sv
sim/tb_mm_block_sched.sv

//--- Makefile
# Verilator build and run for the block matrix multiply scheduler

VERILATOR ?= verilator
TOP       ?= tb_mm_block_sched
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
# Keep running past an assertion error so the testbench ends the run itself
SIM_ARGS  ?= +verilator+error+limit+100

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, the file list or this Makefile changes
$(SIM_BIN): $(SRCS) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
